/* hazard_ctrl.f */
src/hazard_pkg.sv
src/stage_match_if.sv
src/operand_match.sv
src/forward_select.sv
src/stall_detect.sv
src/hazard_ctrl.sv
tests/hazard_ctrl_checker.sv
tests/hazard_ctrl_monitor.sv
tests/hazard_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the hazard controller testbench with Verilator

verilator --binary --timing --timescale 1ns/1ps -f hazard_ctrl.f \
  --top-module hazard_ctrl_tb -o sim_hazard_ctrl > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_hazard_ctrl > sim.log 2>&1 \
  || { echo "Simulation aborted, see sim.log"; exit 1; }

grep -q "Regression passed" sim.log \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL, see sim.log"; exit 1; }

/* src/forward_select.sv */
// Forwarding mux control
// Chooses the source of operand A, operand B and the jump register target
`default_nettype none

module forward_select import hazard_pkg::*; (
  stage_match_if.consumer match,

  output fwd_sel_e  operand_a_sel_o,
  output fwd_sel_e  operand_b_sel_o,
  output jalr_sel_e jalr_sel_o
);

  //////////////////////////////////////////////////
  // Operand forwarding
  //////////////////////////////////////////////////

  always_comb begin
    // Register file unless a newer value is in flight
    operand_a_sel_o = SEL_REGFILE;
    operand_b_sel_o = SEL_REGFILE;

    // Older result first, WB to ID
    if (match.rf_we_wb) begin
      if (match.wb_match[OP_A_PORT]) begin
        operand_a_sel_o = SEL_FW_WB;
      end
      if (match.wb_match[OP_B_PORT]) begin
        operand_b_sel_o = SEL_FW_WB;
      end
    end

    // EX overrides WB as it holds the younger write to the same register
    // A load in EX gets this select too, but ID stalls on it anyway
    if (match.rf_we_ex) begin
      if (match.ex_match[OP_A_PORT]) begin
        operand_a_sel_o = SEL_FW_EX;
      end
      if (match.ex_match[OP_B_PORT]) begin
        operand_b_sel_o = SEL_FW_EX;
      end
    end
  end

  //////////////////////////////////////////////////
  // Jump register target
  //////////////////////////////////////////////////

  // Only WB feeds the jump target; an EX match makes the jalr stall instead
  // The select is a don't care when no jalr is in ID or when it stalls
  always_comb begin
    jalr_sel_o = SELJ_REGFILE;
    if (match.rf_we_wb && match.wb_jalr_match) begin
      jalr_sel_o = SELJ_FW_WB;
    end
  end

endmodule : forward_select

`default_nettype wire

/* src/hazard_ctrl.sv */
// Hazard and operand bypass controller for the ID, EX and WB stages
// Forwarding selects and stall requests, fully combinational
`default_nettype none

module hazard_ctrl import hazard_pkg::*; (
  // ID stage
  input  read_ports_t rf_re_id_i,
  input  rf_addr_t    rf_raddr_a_id_i,
  input  rf_addr_t    rf_raddr_b_id_i,
  input  logic        id_valid_i,
  input  logic        id_jalr_i,
  input  logic        id_csr_i,
  input  logic        id_mret_i,
  input  logic        id_wfi_i,

  // EX stage
  input  logic        ex_valid_i,
  input  logic        ex_rf_we_i,
  input  rf_addr_t    ex_rf_waddr_i,
  input  logic        ex_lsu_en_i,
  input  logic        ex_csr_en_i,
  input  logic        ex_mret_i,
  input  logic        ex_wfi_i,

  // WB stage
  input  logic        wb_valid_i,
  input  logic        wb_rf_we_i,
  input  rf_addr_t    wb_rf_waddr_i,
  input  logic        wb_lsu_en_i,
  input  logic        wb_csr_en_i,
  input  logic        wb_mret_i,
  input  logic        wb_ready_i,

  // Forwarding mux selects
  output fwd_sel_e    operand_a_sel_o,
  output fwd_sel_e    operand_b_sel_o,
  output jalr_sel_e   jalr_sel_o,

  // Stall requests
  output logic        load_stall_o,
  output logic        jalr_stall_o,
  output logic        csr_stall_o,
  output logic        wfi_stall_o
);

  // Shared match results, one producer and two consumers
  stage_match_if match_if ();

  // Write qualification and address compares
  operand_match i_operand_match (
    .rf_re_id_i      (rf_re_id_i),
    .rf_raddr_a_id_i (rf_raddr_a_id_i),
    .rf_raddr_b_id_i (rf_raddr_b_id_i),
    .ex_valid_i      (ex_valid_i),
    .ex_rf_we_i      (ex_rf_we_i),
    .ex_rf_waddr_i   (ex_rf_waddr_i),
    .wb_valid_i      (wb_valid_i),
    .wb_rf_we_i      (wb_rf_we_i),
    .wb_rf_waddr_i   (wb_rf_waddr_i),
    .match           (match_if.producer)
  );

  // Operand and jump target source selection
  forward_select i_forward_select (
    .match           (match_if.consumer),
    .operand_a_sel_o (operand_a_sel_o),
    .operand_b_sel_o (operand_b_sel_o),
    .jalr_sel_o      (jalr_sel_o)
  );

  // Stall requests towards the ID stage
  stall_detect i_stall_detect (
    .match        (match_if.consumer),
    .id_valid_i   (id_valid_i),
    .id_jalr_i    (id_jalr_i),
    .id_csr_i     (id_csr_i),
    .id_mret_i    (id_mret_i),
    .id_wfi_i     (id_wfi_i),
    .ex_valid_i   (ex_valid_i),
    .ex_lsu_en_i  (ex_lsu_en_i),
    .ex_csr_en_i  (ex_csr_en_i),
    .ex_mret_i    (ex_mret_i),
    .ex_wfi_i     (ex_wfi_i),
    .wb_valid_i   (wb_valid_i),
    .wb_lsu_en_i  (wb_lsu_en_i),
    .wb_csr_en_i  (wb_csr_en_i),
    .wb_mret_i    (wb_mret_i),
    .wb_ready_i   (wb_ready_i),
    .load_stall_o (load_stall_o),
    .jalr_stall_o (jalr_stall_o),
    .csr_stall_o  (csr_stall_o),
    .wfi_stall_o  (wfi_stall_o)
  );

endmodule : hazard_ctrl

`default_nettype wire

/* src/hazard_pkg.sv */
// Hazard and bypass controller package
// Register file widths, read port indices and forwarding mux encodings
`default_nettype none

package hazard_pkg;

  //////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////

  // Read ports in ID, operand A and operand B
  localparam int unsigned NUM_READ_PORTS = 2;

  // Register address width for a 32 entry file, x0 reads as zero
  localparam int unsigned RF_ADDR_W = 5;

  // Port index of each operand within the read port vectors
  localparam int unsigned OP_A_PORT = 0;
  localparam int unsigned OP_B_PORT = 1;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  // One bit per read port, used for read enables and match vectors
  typedef logic [NUM_READ_PORTS-1:0] read_ports_t;

  //////////////////////////////////////////////////
  // Forwarding mux selects
  //////////////////////////////////////////////////

  // Operand source in ID; the encoding leaves 2'b11 free
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  // Jump register target source, WB ALU results only
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_sel_e;

endpackage : hazard_pkg

`default_nettype wire

/* src/operand_match.sv */
// Operand address matcher
// Compares the ID read addresses with the EX and WB write addresses
`default_nettype none

module operand_match import hazard_pkg::*; (
  // ID read requests
  input  read_ports_t rf_re_id_i,
  input  rf_addr_t    rf_raddr_a_id_i,
  input  rf_addr_t    rf_raddr_b_id_i,

  // EX write back state
  input  logic        ex_valid_i,
  input  logic        ex_rf_we_i,
  input  rf_addr_t    ex_rf_waddr_i,

  // WB write back state
  input  logic        wb_valid_i,
  input  logic        wb_rf_we_i,
  input  rf_addr_t    wb_rf_waddr_i,

  stage_match_if.producer match
);

  // Read addresses gathered into an array so the generate loop can index them
  rf_addr_t    rf_raddr_id [NUM_READ_PORTS];
  read_ports_t ex_match;
  read_ports_t wb_match;

  assign rf_raddr_id[OP_A_PORT] = rf_raddr_a_id_i;
  assign rf_raddr_id[OP_B_PORT] = rf_raddr_b_id_i;

  // A bubble in EX or WB may carry a stale write enable, so it is masked here once
  assign match.rf_we_ex = ex_rf_we_i && ex_valid_i;
  assign match.rf_we_wb = wb_rf_we_i && wb_valid_i;

  //////////////////////////////////////////////////
  // Per port address compare
  //////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_READ_PORTS; i++) begin : gen_port_match
    // Equal address, not x0, and the port is actually read
    assign ex_match[i] = (ex_rf_waddr_i == rf_raddr_id[i]) && |rf_raddr_id[i] && rf_re_id_i[i];
    assign wb_match[i] = (wb_rf_waddr_i == rf_raddr_id[i]) && |rf_raddr_id[i] && rf_re_id_i[i];
  end

  assign match.ex_match = ex_match;
  assign match.wb_match = wb_match;

  // Jump register base compare on port 0
  // The read enable is left out since jalr always reads rs1
  assign match.ex_jalr_match = (ex_rf_waddr_i == rf_raddr_id[OP_A_PORT]) &&
                               |rf_raddr_id[OP_A_PORT];
  assign match.wb_jalr_match = (wb_rf_waddr_i == rf_raddr_id[OP_A_PORT]) &&
                               |rf_raddr_id[OP_A_PORT];

endmodule : operand_match

`default_nettype wire

/* src/stage_match_if.sv */
// Stage match bundle between the address matcher and its consumers
`default_nettype none

interface stage_match_if import hazard_pkg::*; ();

  // Register file write enables, already qualified with the stage valid bit
  logic        rf_we_ex;
  logic        rf_we_wb;

  // Per port address match against EX and WB
  // Gated with the read enable but not with the write enable
  read_ports_t ex_match;
  read_ports_t wb_match;

  // Operand A against the write address, read enable ignored
  // The jalr decode implies a read of port 0
  logic        ex_jalr_match;
  logic        wb_jalr_match;

  // The matcher drives everything
  modport producer (
    output rf_we_ex,
    output rf_we_wb,
    output ex_match,
    output wb_match,
    output ex_jalr_match,
    output wb_jalr_match
  );

  // Forwarding and stall logic only read
  modport consumer (
    input rf_we_ex,
    input rf_we_wb,
    input ex_match,
    input wb_match,
    input ex_jalr_match,
    input wb_jalr_match
  );

endinterface : stage_match_if

`default_nettype wire

/* src/stall_detect.sv */
// Stall request logic
// Raises the load-use, jump register, CSR and WFI stalls for ID
`default_nettype none

module stall_detect import hazard_pkg::*; (
  stage_match_if.consumer match,

  // ID instruction
  input  logic id_valid_i,
  input  logic id_jalr_i,
  input  logic id_csr_i,
  input  logic id_mret_i,
  input  logic id_wfi_i,

  // EX instruction
  input  logic ex_valid_i,
  input  logic ex_lsu_en_i,
  input  logic ex_csr_en_i,
  input  logic ex_mret_i,
  input  logic ex_wfi_i,

  // WB instruction
  input  logic wb_valid_i,
  input  logic wb_lsu_en_i,
  input  logic wb_csr_en_i,
  input  logic wb_mret_i,
  input  logic wb_ready_i,

  output logic load_stall_o,
  output logic jalr_stall_o,
  output logic csr_stall_o,
  output logic wfi_stall_o
);

  // Valid qualified decode flags
  logic jalr_id;
  logic csr_read_id;
  logic lsu_ex;
  logic lsu_wb;
  logic csr_write_ex;
  logic csr_write_wb;

  //////////////////////////////////////////////////
  // Flag qualification
  //////////////////////////////////////////////////

  assign jalr_id = id_jalr_i && id_valid_i;

  // WFI counts as a CSR reader since it looks at mstatus and the privilege level
  assign csr_read_id = id_valid_i && (id_csr_i || id_mret_i || id_wfi_i);

  assign lsu_ex = ex_lsu_en_i && ex_valid_i;
  assign lsu_wb = wb_lsu_en_i && wb_valid_i;

  // mret updates mstatus implicitly, so it writes CSR state like an explicit access
  assign csr_write_ex = ex_valid_i && (ex_csr_en_i || ex_mret_i);
  assign csr_write_wb = wb_valid_i && (wb_csr_en_i || wb_mret_i);

  //////////////////////////////////////////////////
  // Stall requests
  //////////////////////////////////////////////////

  // Load data only exists in WB, so a load in EX feeding ID has to wait
  // A WB match only hurts while WB is held in a data wait state
  assign load_stall_o = (lsu_ex && match.rf_we_ex && |match.ex_match) ||
                        (!wb_ready_i && match.rf_we_wb && |match.wb_match);

  // The jump target path has no EX bypass and no load bypass from WB
  // A WB ALU result is forwarded instead of stalling
  assign jalr_stall_o = jalr_id &&
                        ((match.rf_we_ex && match.ex_jalr_match) ||
                         (match.rf_we_wb && match.wb_jalr_match && lsu_wb));

  // Conservative ordering; any CSR reader waits for any CSR writer downstream
  assign csr_stall_o = csr_read_id && (csr_write_ex || csr_write_wb);

  // Hold ID while WFI sits in EX so no load or store slips past it
  assign wfi_stall_o = ex_wfi_i && ex_valid_i;

endmodule : stall_detect

`default_nettype wire

/* tests/hazard_ctrl_checker.sv */
// Structural assertions bound into the hazard controller
`default_nettype none

module hazard_ctrl_checker import hazard_pkg::*; (
  input wire logic     clk_i,
  input wire rf_addr_t rf_raddr_a_i,
  input wire rf_addr_t rf_raddr_b_i,
  input wire fwd_sel_e operand_a_sel_i,
  input wire fwd_sel_e operand_b_sel_i,
  input wire logic     id_jalr_i,
  input wire logic     ex_valid_i,
  input wire logic     jalr_stall_i,
  input wire logic     wfi_stall_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions so far
  int assert_fail_count = 0;

  // x0 always reads as zero, so nothing is ever forwarded onto it
  a_fwd_not_x0: assert property (@(posedge clk_i)
    ((operand_a_sel_i == SEL_REGFILE) || (rf_raddr_a_i != '0)) &&
    ((operand_b_sel_i == SEL_REGFILE) || (rf_raddr_b_i != '0)))
    else begin
      $error("Operand forwarded onto a read of register 0");
      assert_fail_count++;
    end

  a_jalr_stall_src: assert property (@(posedge clk_i) jalr_stall_i |-> id_jalr_i)
    else begin
      $error("Jump register stall without a jalr in ID");
      assert_fail_count++;
    end

  a_wfi_stall_src: assert property (@(posedge clk_i) wfi_stall_i |-> ex_valid_i)
    else begin
      $error("WFI stall without a valid EX instruction");
      assert_fail_count++;
    end

endmodule : hazard_ctrl_checker

`default_nettype wire

/* tests/hazard_ctrl_monitor.sv */
// Output monitor for the hazard controller
// Recomputes every output from the inputs and counts mismatches
`default_nettype none

module hazard_ctrl_monitor import hazard_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  input  wire read_ports_t rf_re_id_i,
  input  wire rf_addr_t    rf_raddr_a_id_i,
  input  wire rf_addr_t    rf_raddr_b_id_i,
  input  wire logic        id_valid_i,
  input  wire logic        id_jalr_i,
  input  wire logic        id_csr_i,
  input  wire logic        id_mret_i,
  input  wire logic        id_wfi_i,
  input  wire logic        ex_valid_i,
  input  wire logic        ex_rf_we_i,
  input  wire rf_addr_t    ex_rf_waddr_i,
  input  wire logic        ex_lsu_en_i,
  input  wire logic        ex_csr_en_i,
  input  wire logic        ex_mret_i,
  input  wire logic        ex_wfi_i,
  input  wire logic        wb_valid_i,
  input  wire logic        wb_rf_we_i,
  input  wire rf_addr_t    wb_rf_waddr_i,
  input  wire logic        wb_lsu_en_i,
  input  wire logic        wb_csr_en_i,
  input  wire logic        wb_mret_i,
  input  wire logic        wb_ready_i,
  input  wire fwd_sel_e    operand_a_sel_i,
  input  wire fwd_sel_e    operand_b_sel_i,
  input  wire jalr_sel_e   jalr_sel_i,
  input  wire logic        load_stall_i,
  input  wire logic        jalr_stall_i,
  input  wire logic        csr_stall_i,
  input  wire logic        wfi_stall_i,
  output int               check_count_o,
  output int               error_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    fwd_sel_e  a_sel;
    fwd_sel_e  b_sel;
    jalr_sel_e j_sel;
    logic      load;
    logic      jalr;
    logic      csr;
    logic      wfi;
  } expect_t;

  // Does a read port see a write to the same non-zero register
  function automatic logic reg_hit(logic re, rf_addr_t raddr, rf_addr_t waddr);
    return re && (raddr != '0) && (raddr == waddr);
  endfunction

  function automatic expect_t expected_outputs();
    expect_t  e;
    logic     we_ex;
    logic     we_wb;
    logic     ex_a;
    logic     ex_b;
    logic     wb_a;
    logic     wb_b;
    we_ex = ex_valid_i && ex_rf_we_i;
    we_wb = wb_valid_i && wb_rf_we_i;
    ex_a = we_ex && reg_hit(rf_re_id_i[0], rf_raddr_a_id_i, ex_rf_waddr_i);
    ex_b = we_ex && reg_hit(rf_re_id_i[1], rf_raddr_b_id_i, ex_rf_waddr_i);
    wb_a = we_wb && reg_hit(rf_re_id_i[0], rf_raddr_a_id_i, wb_rf_waddr_i);
    wb_b = we_wb && reg_hit(rf_re_id_i[1], rf_raddr_b_id_i, wb_rf_waddr_i);
    // The younger EX result wins over WB
    e.a_sel = ex_a ? SEL_FW_EX : (wb_a ? SEL_FW_WB : SEL_REGFILE);
    e.b_sel = ex_b ? SEL_FW_EX : (wb_b ? SEL_FW_WB : SEL_REGFILE);
    // Jump target compares ignore the read enable
    e.j_sel = (we_wb && reg_hit(1'b1, rf_raddr_a_id_i, wb_rf_waddr_i)) ?
              SELJ_FW_WB : SELJ_REGFILE;
    e.load = (ex_valid_i && ex_lsu_en_i && (ex_a || ex_b)) ||
             (!wb_ready_i && (wb_a || wb_b));
    e.jalr = id_valid_i && id_jalr_i &&
             ((we_ex && reg_hit(1'b1, rf_raddr_a_id_i, ex_rf_waddr_i)) ||
              (we_wb && wb_lsu_en_i && reg_hit(1'b1, rf_raddr_a_id_i, wb_rf_waddr_i)));
    e.csr = id_valid_i && (id_csr_i || id_mret_i || id_wfi_i) &&
            ((ex_valid_i && (ex_csr_en_i || ex_mret_i)) ||
             (wb_valid_i && (wb_csr_en_i || wb_mret_i)));
    e.wfi = ex_valid_i && ex_wfi_i;
    return e;
  endfunction

  task automatic compare_field(string name, logic [1:0] exp_val, logic [1:0] act_val);
    if (exp_val !== act_val) begin
      error_count_o++;
      $display("** Error at %0t: %s expected %0d, actual %0d", $time, name, exp_val, act_val);
    end
  endtask

  initial begin
    check_count_o = 0;
    error_count_o = 0;
  end

  // Inputs settle 10 ns after each edge, so the next edge sees stable outputs
  always @(posedge clk_i) begin
    expect_t e;
    if (!reset_i) begin
      e = expected_outputs();
      check_count_o++;
      compare_field("operand_a_sel_o", e.a_sel, operand_a_sel_i);
      compare_field("operand_b_sel_o", e.b_sel, operand_b_sel_i);
      compare_field("jalr_sel_o", {1'b0, e.j_sel}, {1'b0, jalr_sel_i});
      compare_field("load_stall_o", {1'b0, e.load}, {1'b0, load_stall_i});
      compare_field("jalr_stall_o", {1'b0, e.jalr}, {1'b0, jalr_stall_i});
      compare_field("csr_stall_o", {1'b0, e.csr}, {1'b0, csr_stall_i});
      compare_field("wfi_stall_o", {1'b0, e.wfi}, {1'b0, wfi_stall_i});
    end
  end

endmodule : hazard_ctrl_monitor

`default_nettype wire

/* tests/hazard_ctrl_tb.sv */
// Testbench for the hazard controller
// Directed hazard cases followed by a seeded random regression
`default_nettype none

module hazard_ctrl_tb import hazard_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // 10 reset cycles, 30 directed and 2000 random vectors, plus margin
  localparam int unsigned MAX_CYCLES = 2200;
  localparam int unsigned NUM_RANDOM = 2000;

  logic        clk;
  logic        reset_i;
  read_ports_t rf_re_id;
  rf_addr_t    raddr_a;
  rf_addr_t    raddr_b;
  logic        id_valid, id_jalr, id_csr, id_mret, id_wfi;
  logic        ex_valid, ex_we, ex_lsu, ex_csr, ex_mret, ex_wfi;
  rf_addr_t    ex_waddr;
  logic        wb_valid, wb_we, wb_lsu, wb_csr, wb_mret, wb_ready;
  rf_addr_t    wb_waddr;
  fwd_sel_e    a_sel;
  fwd_sel_e    b_sel;
  jalr_sel_e   j_sel;
  logic        load_stall, jalr_stall, csr_stall, wfi_stall;
  int          check_count;
  int          error_count;
  int          cycle_count;
  int          seed;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  hazard_ctrl i_dut (
    .rf_re_id_i(rf_re_id), .rf_raddr_a_id_i(raddr_a), .rf_raddr_b_id_i(raddr_b),
    .id_valid_i(id_valid), .id_jalr_i(id_jalr), .id_csr_i(id_csr),
    .id_mret_i(id_mret), .id_wfi_i(id_wfi),
    .ex_valid_i(ex_valid), .ex_rf_we_i(ex_we), .ex_rf_waddr_i(ex_waddr),
    .ex_lsu_en_i(ex_lsu), .ex_csr_en_i(ex_csr), .ex_mret_i(ex_mret), .ex_wfi_i(ex_wfi),
    .wb_valid_i(wb_valid), .wb_rf_we_i(wb_we), .wb_rf_waddr_i(wb_waddr),
    .wb_lsu_en_i(wb_lsu), .wb_csr_en_i(wb_csr), .wb_mret_i(wb_mret), .wb_ready_i(wb_ready),
    .operand_a_sel_o(a_sel), .operand_b_sel_o(b_sel), .jalr_sel_o(j_sel),
    .load_stall_o(load_stall), .jalr_stall_o(jalr_stall),
    .csr_stall_o(csr_stall), .wfi_stall_o(wfi_stall)
  );

  hazard_ctrl_monitor i_monitor (
    .clk_i(clk), .reset_i(reset_i), .rf_re_id_i(rf_re_id),
    .rf_raddr_a_id_i(raddr_a), .rf_raddr_b_id_i(raddr_b),
    .id_valid_i(id_valid), .id_jalr_i(id_jalr), .id_csr_i(id_csr),
    .id_mret_i(id_mret), .id_wfi_i(id_wfi),
    .ex_valid_i(ex_valid), .ex_rf_we_i(ex_we), .ex_rf_waddr_i(ex_waddr),
    .ex_lsu_en_i(ex_lsu), .ex_csr_en_i(ex_csr), .ex_mret_i(ex_mret), .ex_wfi_i(ex_wfi),
    .wb_valid_i(wb_valid), .wb_rf_we_i(wb_we), .wb_rf_waddr_i(wb_waddr),
    .wb_lsu_en_i(wb_lsu), .wb_csr_en_i(wb_csr), .wb_mret_i(wb_mret), .wb_ready_i(wb_ready),
    .operand_a_sel_i(a_sel), .operand_b_sel_i(b_sel), .jalr_sel_i(j_sel),
    .load_stall_i(load_stall), .jalr_stall_i(jalr_stall),
    .csr_stall_i(csr_stall), .wfi_stall_i(wfi_stall),
    .check_count_o(check_count), .error_count_o(error_count)
  );

  bind hazard_ctrl hazard_ctrl_checker i_checker (
    .clk_i(hazard_ctrl_tb.clk), .rf_raddr_a_i(rf_raddr_a_id_i),
    .rf_raddr_b_i(rf_raddr_b_id_i), .operand_a_sel_i(operand_a_sel_o),
    .operand_b_sel_i(operand_b_sel_o), .id_jalr_i(id_jalr_i), .ex_valid_i(ex_valid_i),
    .jalr_stall_i(jalr_stall_o), .wfi_stall_i(wfi_stall_o)
  );

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Inputs change 10 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic clear_inputs();
    rf_re_id = '0;
    raddr_a = '0;
    raddr_b = '0;
    {id_valid, id_jalr, id_csr, id_mret, id_wfi} = '0;
    {ex_valid, ex_we, ex_lsu, ex_csr, ex_mret, ex_wfi} = '0;
    {wb_valid, wb_we, wb_lsu, wb_csr, wb_mret} = '0;
    ex_waddr = '0;
    wb_waddr = '0;
    wb_ready = 1'b1;
  endtask

  // Register traffic, with an optional valid jalr in ID
  task automatic forward_case(logic jalr, logic [1:0] re, int a, int b,
                              logic exv, logic exwe, int exa, logic exlsu,
                              logic wbv, logic wbwe, int wba, logic wblsu, logic wbrdy);
    next_cycle();
    clear_inputs();
    id_valid = jalr;
    id_jalr = jalr;
    rf_re_id = re;
    raddr_a = rf_addr_t'(a);
    raddr_b = rf_addr_t'(b);
    {ex_valid, ex_we, ex_lsu} = {exv, exwe, exlsu};
    ex_waddr = rf_addr_t'(exa);
    {wb_valid, wb_we, wb_lsu, wb_ready} = {wbv, wbwe, wblsu, wbrdy};
    wb_waddr = rf_addr_t'(wba);
  endtask

  // CSR, mret and WFI traffic without register writes
  task automatic control_case(logic idv, logic csr, logic mret, logic wfi,
                              logic exv, logic excsr, logic exmret, logic exwfi,
                              logic wbv, logic wbcsr, logic wbmret);
    next_cycle();
    clear_inputs();
    {id_valid, id_csr, id_mret, id_wfi} = {idv, csr, mret, wfi};
    {ex_valid, ex_csr, ex_mret, ex_wfi} = {exv, excsr, exmret, exwfi};
    {wb_valid, wb_csr, wb_mret} = {wbv, wbcsr, wbmret};
  endtask

  function automatic logic rand_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // Only x0 to x3, so that matches happen often
  function automatic rf_addr_t rand_addr();
    int r;
    r = $random(seed);
    return rf_addr_t'(r[1:0]);
  endfunction

  task automatic random_vector();
    next_cycle();
    rf_re_id = {rand_bit(), rand_bit()};
    raddr_a = rand_addr();
    raddr_b = rand_addr();
    {id_valid, id_jalr, id_csr, id_mret, id_wfi} = {rand_bit(), rand_bit(), rand_bit(),
                                                    rand_bit(), rand_bit()};
    {ex_valid, ex_we, ex_lsu} = {rand_bit(), rand_bit(), rand_bit()};
    {ex_csr, ex_mret, ex_wfi} = {rand_bit(), rand_bit(), rand_bit()};
    ex_waddr = rand_addr();
    {wb_valid, wb_we, wb_lsu} = {rand_bit(), rand_bit(), rand_bit()};
    {wb_csr, wb_mret, wb_ready} = {rand_bit(), rand_bit(), rand_bit()};
    wb_waddr = rand_addr();
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed = 32'he89c_65c2;
    reset_i = 1'b1;
    clear_inputs();
    repeat (10) @(posedge clk);
    #10;
    reset_i = 1'b0;

    // Forwarding priority, x0 and disabled ports
    forward_case(0, 2'b11, 1, 2, 1, 1, 1, 0, 1, 1, 1, 0, 1);
    forward_case(0, 2'b11, 1, 2, 0, 0, 0, 0, 1, 1, 2, 0, 1);
    forward_case(0, 2'b11, 0, 0, 1, 1, 0, 0, 1, 1, 0, 0, 1);
    forward_case(0, 2'b00, 1, 2, 1, 1, 1, 0, 1, 1, 2, 0, 1);
    forward_case(0, 2'b11, 5, 5, 1, 1, 5, 0, 1, 1, 5, 0, 1);
    forward_case(0, 2'b11, 1, 2, 1, 0, 1, 0, 1, 1, 1, 0, 1);
    forward_case(0, 2'b11, 1, 2, 0, 1, 1, 0, 0, 1, 2, 0, 1);
    // Load-use stalls
    forward_case(0, 2'b01, 4, 0, 1, 1, 4, 1, 0, 0, 0, 0, 1);
    forward_case(0, 2'b10, 0, 4, 1, 1, 4, 1, 0, 0, 0, 0, 1);
    forward_case(0, 2'b01, 4, 0, 0, 1, 4, 1, 0, 0, 0, 0, 1);
    forward_case(0, 2'b01, 4, 0, 1, 0, 4, 1, 0, 0, 0, 0, 1);
    forward_case(0, 2'b01, 4, 0, 0, 0, 0, 0, 1, 1, 4, 1, 0);
    forward_case(0, 2'b01, 4, 0, 0, 0, 0, 0, 1, 1, 4, 1, 1);
    forward_case(0, 2'b01, 4, 0, 0, 0, 0, 0, 0, 1, 4, 1, 0);
    // Jump register path
    forward_case(1, 2'b01, 6, 0, 1, 1, 6, 0, 0, 0, 0, 0, 1);
    forward_case(1, 2'b01, 6, 0, 0, 0, 0, 0, 1, 1, 6, 1, 1);
    forward_case(1, 2'b01, 6, 0, 0, 0, 0, 0, 1, 1, 6, 0, 1);
    forward_case(1, 2'b00, 6, 0, 0, 0, 0, 0, 1, 1, 6, 0, 1);
    forward_case(1, 2'b01, 0, 0, 1, 1, 0, 0, 1, 1, 0, 1, 1);
    forward_case(1, 2'b01, 6, 0, 1, 1, 7, 0, 1, 1, 8, 1, 1);
    // CSR ordering
    control_case(1, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0);
    control_case(1, 0, 1, 0, 0, 0, 0, 0, 1, 0, 1);
    control_case(1, 0, 0, 1, 1, 0, 1, 0, 0, 0, 0);
    control_case(1, 1, 0, 0, 0, 1, 0, 0, 0, 1, 0);
    control_case(0, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0);
    control_case(1, 0, 0, 0, 1, 1, 0, 0, 1, 1, 0);
    control_case(1, 1, 0, 0, 0, 0, 0, 0, 1, 1, 0);
    // WFI in EX
    control_case(0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0);
    control_case(1, 1, 0, 0, 1, 0, 0, 1, 0, 0, 0);
    control_case(0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0);

    repeat (NUM_RANDOM) random_vector();

    // Let the monitor sample the last vector
    @(posedge clk);
    #1;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
             i_dut.i_checker.assert_fail_count);
    if (error_count == 0 && i_dut.i_checker.assert_fail_count == 0 && check_count > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial cycle_count = 0;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

endmodule : hazard_ctrl_tb

`default_nettype wire
